// ==== common/pcs_reorder_pkg.sv ====
package pcs_reorder_pkg;

    // one 64b/66b block as seen on a lane
    localparam int NB_BLOCK   = 66;
    localparam int NB_SYNC    = 2;
    localparam int NB_PAYLOAD = 64;

    // block plus the marker tag, tag in the msb
    localparam int NB_TAGGED  = 67;

    // lane number field carried inside a marker
    localparam int NB_LANE_ID = 8;

    // sync header values
    localparam logic [NB_SYNC-1:0] SYNC_DATA = 2'b01;
    localparam logic [NB_SYNC-1:0] SYNC_CTRL = 2'b10;

    // fixed marker pattern, same on every lane
    localparam logic [23:0] AM_CODE = 24'hc1_6821;

    // the same 66-bit word, read either as a marker or as plain data
    typedef union packed {
        struct packed {
            logic [NB_SYNC-1:0]    sync;
            logic [23:0]           code;
            logic [NB_LANE_ID-1:0] lane_num;
            logic [31:0]           filler;
        } am;
        struct packed {
            logic [NB_SYNC-1:0]    sync;
            logic [NB_PAYLOAD-1:0] payload;
        } data;
    } pcs_block_u;

    // marker = control header and the marker code in place
    function automatic logic is_alignment_marker(input pcs_block_u blk);
        logic hdr_ok;
        logic code_ok;
        hdr_ok  = (blk.am.sync == SYNC_CTRL);
        code_ok = (blk.am.code == AM_CODE);
        return hdr_ok && code_ok;
    endfunction

    // payload view, used when building data blocks
    function automatic pcs_block_u make_data_block(input logic [NB_PAYLOAD-1:0] payload);
        pcs_block_u blk;
        blk.data.sync    = SYNC_DATA;
        blk.data.payload = payload;
        return blk;
    endfunction

endpackage

// ==== src/lane_am_lock.sv ====
module lane_am_lock
#(
    parameter int AM_PERIOD = 16
)
(
    input  logic                                   i_clock,
    input  logic                                   i_reset,
    input  logic                                   i_enable,
    input  logic                                   i_valid,
    input  pcs_reorder_pkg::pcs_block_u            i_block,
    output logic [pcs_reorder_pkg::NB_TAGGED-1:0]  o_block,
    output logic                                   o_lock,
    output logic [pcs_reorder_pkg::NB_LANE_ID-1:0] o_lane_id
);
    import pcs_reorder_pkg::*;

    localparam int NB_COUNT = (AM_PERIOD > 1) ? $clog2(AM_PERIOD) : 1;
    localparam logic [NB_COUNT-1:0] LAST_BEAT = NB_COUNT'(AM_PERIOD - 1);

    logic                  accept;
    logic                  is_marker;
    logic                  id_match;
    logic                  at_expected;
    logic                  cand;
    logic [NB_COUNT-1:0]   beat_count;
    logic [NB_LANE_ID-1:0] lane_id;

    assign accept      = i_enable && i_valid;
    assign is_marker   = is_alignment_marker(i_block);
    assign id_match    = is_marker && (i_block.am.lane_num == lane_id);

    // beat_count is the number of beats since the last marker, minus one
    assign at_expected = (beat_count == LAST_BEAT);

    assign o_lane_id = lane_id;

    // tagged copy of the accepted block
    always_ff @(posedge i_clock)
    begin
        if (accept)
        begin
            o_block <= {is_marker, i_block};
        end
    end

    // hunt -> candidate -> locked
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            cand       <= 1'b0;
            o_lock     <= 1'b0;
            beat_count <= '0;
            lane_id    <= '0;
        end
        else if (accept)
        begin
            if (!cand && !o_lock)
            begin
                // hunting, any marker becomes a candidate
                if (is_marker)
                begin
                    cand       <= 1'b1;
                    lane_id    <= i_block.am.lane_num;
                    beat_count <= '0;
                end
            end
            else if (at_expected)
            begin
                beat_count <= '0;
                if (id_match)
                begin
                    o_lock <= 1'b1;
                    cand   <= 1'b0;
                end
                else
                begin
                    o_lock <= 1'b0;
                    // a marker with another number restarts the candidate
                    cand   <= is_marker;
                    if (is_marker)
                    begin
                        lane_id <= i_block.am.lane_num;
                    end
                end
            end
            else
            begin
                beat_count <= beat_count + 1'b1;
            end
        end
    end

endmodule

// ==== src/lane_reorder.sv ====
module lane_reorder
#(
    parameter  int N_LANES = 4,
    localparam int NB_SEL  = (N_LANES > 1) ? $clog2(N_LANES) : 1
)
(
    input  logic                                           i_clock,
    input  logic                                           i_reset,
    input  logic                                           i_rf_reset_order,
    input  logic                                           i_enable,
    input  logic [N_LANES-1:0]                             i_lock,
    input  logic [N_LANES*pcs_reorder_pkg::NB_LANE_ID-1:0] i_lane_ids,
    output logic [N_LANES*NB_SEL-1:0]                      o_selector,
    output logic                                           o_update,
    output logic                                           o_order_error
);
    import pcs_reorder_pkg::*;

    logic              all_lock;
    logic              all_lock_d;
    logic              start;
    logic              busy;
    logic [NB_SEL-1:0] scan_idx;
    logic              scan_last;
    logic              scan_err;
    logic              hit_found;
    logic              hit_multi;
    logic [NB_SEL-1:0] hit_lane;

    assign all_lock  = &i_lock;
    assign start     = i_enable && all_lock && (!all_lock_d || i_rf_reset_order);
    assign scan_last = (scan_idx == NB_SEL'(N_LANES - 1));

    // which physical lane carries logical id scan_idx
    always_comb
    begin
        hit_found = 1'b0;
        hit_multi = 1'b0;
        hit_lane  = '0;
        for (int j = 0; j < N_LANES; j++)
        begin
            if (i_lane_ids[j*NB_LANE_ID +: NB_LANE_ID] == NB_LANE_ID'(scan_idx))
            begin
                hit_multi = hit_multi || hit_found;
                hit_found = 1'b1;
                hit_lane  = NB_SEL'(j);
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            all_lock_d <= 1'b0;
        end
        else if (i_enable)
        begin
            all_lock_d <= all_lock;
        end
    end

    // one logical id per cycle, update after the last one
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            busy          <= 1'b0;
            scan_idx      <= '0;
            scan_err      <= 1'b0;
            o_update      <= 1'b0;
            o_order_error <= 1'b0;
        end
        else
        begin
            o_update <= 1'b0;
            if (i_enable)
            begin
                if (start)
                begin
                    busy     <= 1'b1;
                    scan_idx <= '0;
                    scan_err <= 1'b0;
                end
                else if (busy && !all_lock)
                begin
                    // lost a lane mid-scan, wait for the next all-locked edge
                    busy <= 1'b0;
                end
                else if (busy)
                begin
                    if (scan_last)
                    begin
                        busy <= 1'b0;
                        if (scan_err || !hit_found || hit_multi)
                        begin
                            o_order_error <= 1'b1;
                        end
                        else
                        begin
                            o_update      <= 1'b1;
                            o_order_error <= 1'b0;
                        end
                    end
                    else
                    begin
                        scan_idx <= scan_idx + 1'b1;
                        scan_err <= scan_err || !hit_found || hit_multi;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_enable && busy)
        begin
            o_selector[scan_idx*NB_SEL +: NB_SEL] <= hit_lane;
        end
    end

endmodule

// ==== src/lane_swap.sv ====
module lane_swap
#(
    parameter  int N_LANES = 4,
    localparam int NB_SEL  = (N_LANES > 1) ? $clog2(N_LANES) : 1
)
(
    input  logic                                          i_clock,
    input  logic                                          i_reset,
    input  logic                                          i_enable,
    input  logic                                          i_valid_d,
    input  logic [N_LANES*pcs_reorder_pkg::NB_TAGGED-1:0] i_data,
    input  logic [N_LANES*NB_SEL-1:0]                     i_selector,
    input  logic                                          i_update,
    input  logic                                          i_any_unlock,
    output logic [N_LANES*pcs_reorder_pkg::NB_BLOCK-1:0]  o_data,
    output logic [N_LANES-1:0]                            o_tag,
    output logic                                          o_valid,
    output logic                                          o_aligned
);
    import pcs_reorder_pkg::*;

    logic [N_LANES*NB_SEL-1:0]    active_sel;
    logic [N_LANES*NB_TAGGED-1:0] swapped;
    logic [N_LANES*NB_TAGGED-1:0] swapped_q;
    logic                         advance;

    assign advance = i_enable && i_valid_d;

    always_ff @(posedge i_clock)
    begin
        if (i_update)
        begin
            active_sel <= i_selector;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_aligned <= 1'b0;
            o_valid   <= 1'b0;
        end
        else
        begin
            if (i_any_unlock)
            begin
                o_aligned <= 1'b0;
            end
            else if (i_update)
            begin
                o_aligned <= 1'b1;
            end
            // the beat that carried the unlock is dropped too
            o_valid <= advance && o_aligned && !i_any_unlock;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (advance)
        begin
            swapped_q <= swapped;
        end
    end

    // logical lane k takes physical lane active_sel[k]
    for (genvar k = 0; k < N_LANES; k++)
    begin : g_lane
        logic [NB_SEL-1:0] src;

        assign src = active_sel[k*NB_SEL +: NB_SEL];
        assign swapped[k*NB_TAGGED +: NB_TAGGED] = i_data[src*NB_TAGGED +: NB_TAGGED];
        assign o_data[k*NB_BLOCK +: NB_BLOCK]    = swapped_q[k*NB_TAGGED +: NB_BLOCK];
        assign o_tag[k]                          = swapped_q[k*NB_TAGGED + NB_BLOCK];
    end

endmodule

// ==== src/pcs_reorder_top.sv ====
module pcs_reorder_top
#(
    parameter  int N_LANES   = 4,
    parameter  int AM_PERIOD = 16,
    localparam int NB_SEL    = (N_LANES > 1) ? $clog2(N_LANES) : 1
)
(
    input  logic                                         i_clock,
    input  logic                                         i_reset,
    input  logic                                         i_rf_reset_order,
    input  logic                                         i_enable,
    input  logic                                         i_valid,
    input  logic [N_LANES*pcs_reorder_pkg::NB_BLOCK-1:0] i_data,
    output logic [N_LANES*pcs_reorder_pkg::NB_BLOCK-1:0] o_data,
    output logic [N_LANES-1:0]                           o_tag,
    output logic                                         o_valid,
    output logic                                         o_aligned,
    output logic                                         o_order_error
);
    import pcs_reorder_pkg::*;

    logic [N_LANES*NB_TAGGED-1:0]  tagged_bus;
    logic [N_LANES-1:0]            lock_bus;
    logic [N_LANES*NB_LANE_ID-1:0] lane_id_bus;
    logic [N_LANES*NB_SEL-1:0]     selector;
    logic                          update;
    logic                          valid_d;

    // valid follows the block into the lock registers
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            valid_d <= 1'b0;
        end
        else if (i_enable)
        begin
            valid_d <= i_valid;
        end
    end

    for (genvar g = 0; g < N_LANES; g++)
    begin : g_lock
        lane_am_lock
        #(
            .AM_PERIOD (AM_PERIOD)
        )
        u_lane_am_lock
        (
            .i_clock   (i_clock),
            .i_reset   (i_reset),
            .i_enable  (i_enable),
            .i_valid   (i_valid),
            .i_block   (pcs_block_u'(i_data[g*NB_BLOCK +: NB_BLOCK])),
            .o_block   (tagged_bus[g*NB_TAGGED +: NB_TAGGED]),
            .o_lock    (lock_bus[g]),
            .o_lane_id (lane_id_bus[g*NB_LANE_ID +: NB_LANE_ID])
        );
    end

    lane_reorder
    #(
        .N_LANES (N_LANES)
    )
    u_lane_reorder
    (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_rf_reset_order (i_rf_reset_order),
        .i_enable         (i_enable),
        .i_lock           (lock_bus),
        .i_lane_ids       (lane_id_bus),
        .o_selector       (selector),
        .o_update         (update),
        .o_order_error    (o_order_error)
    );

    lane_swap
    #(
        .N_LANES (N_LANES)
    )
    u_lane_swap
    (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_enable     (i_enable),
        .i_valid_d    (valid_d),
        .i_data       (tagged_bus),
        .i_selector   (selector),
        .i_update     (update),
        .i_any_unlock (~&lock_bus),
        .o_data       (o_data),
        .o_tag        (o_tag),
        .o_valid      (o_valid),
        .o_aligned    (o_aligned)
    );

endmodule

// ==== verif/tb_pcs_reorder.sv ====
module tb_pcs_reorder;
    timeunit 1ns;
    timeprecision 1ps;
    import pcs_reorder_pkg::*;

    localparam int N_LANES    = 4;
    localparam int AM_PERIOD  = 16;
    localparam int NB_BUS     = N_LANES * NB_BLOCK;
    localparam int WAIT_LIMIT = 4 * AM_PERIOD + N_LANES + 8;
    localparam int N_CHECK    = 64;
    localparam int N_RANDOM   = 120;
    localparam int MAX_CYCLES = 2 * (8 * WAIT_LIMIT + 2 * N_CHECK + 2 * N_RANDOM + 100);

    logic              i_clock;
    logic              i_reset;
    logic              i_rf_reset_order;
    logic              i_enable;
    logic              i_valid;
    logic [NB_BUS-1:0] i_data;
    logic [NB_BUS-1:0] o_data;
    logic [N_LANES-1:0] o_tag;
    logic              o_valid;
    logic              o_aligned;
    logic              o_order_error;

    int                 ids[N_LANES];
    int                 beat_idx;
    int                 corrupt_lane;
    int                 err_count;
    int                 check_count;
    int                 tests_passed;
    int                 tests_failed;
    int                 cycle_count;
    bit                 checking;
    logic [NB_BUS-1:0]  next_exp;
    logic [N_LANES-1:0] next_tag;
    logic [NB_BUS-1:0]  exp_data_q[$];
    logic [N_LANES-1:0] exp_tag_q[$];

    pcs_reorder_top
    #(
        .N_LANES   (N_LANES),
        .AM_PERIOD (AM_PERIOD)
    )
    u_dut
    (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_rf_reset_order (i_rf_reset_order),
        .i_enable         (i_enable),
        .i_valid          (i_valid),
        .i_data           (i_data),
        .o_data           (o_data),
        .o_tag            (o_tag),
        .o_valid          (o_valid),
        .o_aligned        (o_aligned),
        .o_order_error    (o_order_error)
    );

    always #10 i_clock = ~i_clock;

    always @(posedge i_clock)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("run stopped, no finish after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_block(input string name, input pcs_block_u exp, input pcs_block_u act);
        check_count++;
        if (exp !== act)
        begin
            err_count++;
            $display("FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (exp !== act)
        begin
            err_count++;
            $display("FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic report_fail(input string msg);
        err_count++;
        $display("ERROR %s", msg);
    endtask

    // queue the expected logical-order beat for every accepted input beat
    always @(posedge i_clock)
    begin
        if (checking && i_enable && i_valid)
        begin
            exp_data_q.push_back(next_exp);
            exp_tag_q.push_back(next_tag);
        end
    end

    always @(negedge i_clock)
    begin
        logic [NB_BUS-1:0]  exp_bus;
        logic [N_LANES-1:0] exp_tag;
        if (checking && o_valid)
        begin
            if (exp_data_q.size() == 0)
            begin
                report_fail("output beat came out with none expected");
            end
            else
            begin
                exp_bus = exp_data_q.pop_front();
                exp_tag = exp_tag_q.pop_front();
                for (int k = 0; k < N_LANES; k++)
                begin
                    check_block($sformatf("data lane %0d", k),
                                exp_bus[k*NB_BLOCK +: NB_BLOCK], o_data[k*NB_BLOCK +: NB_BLOCK]);
                    check_bit($sformatf("tag lane %0d", k), exp_tag[k], o_tag[k]);
                end
            end
        end
    end

    task automatic shuffle_ids();
        int j;
        int t;
        for (int p = 0; p < N_LANES; p++)
        begin
            ids[p] = p;
        end
        for (int i = N_LANES - 1; i > 0; i--)
        begin
            j      = $urandom % (i + 1);
            t      = ids[i];
            ids[i] = ids[j];
            ids[j] = t;
        end
    endtask

    // one cycle of stimulus with a marker every AM_PERIOD accepted beats
    task automatic drive_cycle(input logic en, input logic vld, input logic rf);
        pcs_block_u         blk;
        logic [NB_BUS-1:0]  bus;
        logic [NB_BUS-1:0]  exp_bus;
        logic [N_LANES-1:0] exp_tag;
        logic               marker;
        @(posedge i_clock);
        #2;
        marker  = ((beat_idx % AM_PERIOD) == 0);
        bus     = '0;
        exp_bus = '0;
        exp_tag = '0;
        for (int p = 0; p < N_LANES; p++)
        begin
            if (marker)
            begin
                blk.am.sync     = SYNC_CTRL;
                blk.am.code     = (p == corrupt_lane) ? ~AM_CODE : AM_CODE;
                blk.am.lane_num = NB_LANE_ID'(ids[p]);
                blk.am.filler   = $urandom;
            end
            else
            begin
                blk = make_data_block({$urandom, $urandom});
            end
            bus[p*NB_BLOCK +: NB_BLOCK]          = blk;
            exp_bus[ids[p]*NB_BLOCK +: NB_BLOCK] = blk;
            exp_tag[ids[p]]                      = marker && (p != corrupt_lane);
        end
        i_data           = bus;
        i_enable         = en;
        i_valid          = vld;
        i_rf_reset_order = rf;
        next_exp         = exp_bus;
        next_tag         = exp_tag;
        if (en && vld)
        begin
            beat_idx++;
        end
    endtask

    task automatic wait_aligned(input logic level);
        bit ok;
        ok = 0;
        for (int n = 0; n < WAIT_LIMIT && !ok; n++)
        begin
            if (o_aligned === level)
                ok = 1;
            else
                drive_cycle(1, 1, 0);
        end
        if (!ok)
            report_fail($sformatf("o_aligned never went to %b", level));
    endtask

    task automatic wait_order_error();
        bit ok;
        ok = 0;
        for (int n = 0; n < WAIT_LIMIT && !ok; n++)
        begin
            if (o_order_error === 1'b1)
                ok = 1;
            else
                drive_cycle(1, 1, 0);
        end
        if (!ok)
            report_fail("o_order_error never rose with a duplicate lane id");
    endtask

    // drain the pipeline with idle beats, then start the model
    task automatic open_window();
        checking = 0;
        repeat (3) drive_cycle(1, 0, 0);
        exp_data_q.delete();
        exp_tag_q.delete();
        checking = 1;
    endtask

    task automatic close_window();
        repeat (3) drive_cycle(1, 0, 0);
        checking = 0;
        if (exp_data_q.size() != 0)
            report_fail($sformatf("%0d expected beats never came out", exp_data_q.size()));
        exp_data_q.delete();
        exp_tag_q.delete();
    endtask

    task automatic finish_test(input string name, input int start_err);
        if (err_count == start_err)
        begin
            tests_passed++;
            $display("test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - start_err);
        end
    endtask

    initial
    begin
        int  start_err;
        int  old_ids[N_LANES];
        bit  same;
        int  r;
        i_clock          = 0;
        i_reset          = 1;
        i_rf_reset_order = 0;
        i_enable         = 0;
        i_valid          = 0;
        i_data           = '0;
        beat_idx         = 0;
        corrupt_lane     = -1;
        checking         = 0;
        void'($urandom(32'h6e8a_8d6f));
        shuffle_ids();
        repeat (5) @(posedge i_clock);
        #2;
        i_reset = 0;

        start_err = err_count;
        check_bit("reset o_valid", 1'b0, o_valid);
        check_bit("reset o_aligned", 1'b0, o_aligned);
        check_bit("reset o_order_error", 1'b0, o_order_error);
        for (int n = 0; n <= AM_PERIOD; n++)
        begin
            drive_cycle(1, 1, 0);
            check_bit("pre-lock o_valid", 1'b0, o_valid);
            check_bit("pre-lock o_aligned", 1'b0, o_aligned);
        end
        finish_test("reset_and_lock", start_err);

        start_err = err_count;
        wait_aligned(1);
        open_window();
        repeat (N_CHECK) drive_cycle(1, 1, 0);
        close_window();
        finish_test("aligned_stream", start_err);

        start_err = err_count;
        open_window();
        for (int n = 0; n < N_RANDOM; n++)
        begin
            r = $urandom % 8;
            if (r == 0)
                repeat (1 + $urandom % 3) drive_cycle(0, 1'($urandom % 2), 0);
            else
                drive_cycle(1, r != 1, 0);
        end
        close_window();
        finish_test("idle_and_enable_gaps", start_err);

        start_err = err_count;
        old_ids = ids;
        same    = 1;
        while (same)
        begin
            shuffle_ids();
            same = 1;
            for (int p = 0; p < N_LANES; p++)
            begin
                if (ids[p] != old_ids[p])
                    same = 0;
            end
        end
        wait_aligned(0);
        wait_aligned(1);
        drive_cycle(1, 1, 1);
        repeat (N_LANES + 3) drive_cycle(1, 1, 0);
        check_bit("remap o_aligned", 1'b1, o_aligned);
        open_window();
        repeat (N_CHECK) drive_cycle(1, 1, 0);
        close_window();
        finish_test("remap", start_err);

        start_err = err_count;
        old_ids = ids;
        ids[1]  = ids[0];
        wait_order_error();
        for (int n = 0; n < 8; n++)
        begin
            drive_cycle(1, 1, 0);
            check_bit("dup id o_aligned", 1'b0, o_aligned);
            check_bit("dup id o_valid", 1'b0, o_valid);
        end
        finish_test("duplicate_id", start_err);

        start_err = err_count;
        ids = old_ids;
        wait_aligned(1);
        check_bit("restored o_order_error", 1'b0, o_order_error);
        while ((beat_idx % AM_PERIOD) != 0)
            drive_cycle(1, 1, 0);
        corrupt_lane = 2;
        drive_cycle(1, 1, 0);
        corrupt_lane = -1;
        repeat (2) drive_cycle(1, 1, 0);
        for (int n = 0; n < 10; n++)
        begin
            drive_cycle(1, 1, 0);
            check_bit("corrupt o_aligned", 1'b0, o_aligned);
            check_bit("corrupt o_valid", 1'b0, o_valid);
        end
        finish_test("corrupt_marker", start_err);

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, err_count);
        if (err_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== files.f ====
common/pcs_reorder_pkg.sv
src/lane_am_lock.sv
src/lane_reorder.sv
src/lane_swap.sv
src/pcs_reorder_top.sv
verif/tb_pcs_reorder.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing
TOP       = tb_pcs_reorder
FILE_LIST = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: simulate clean

# build, run, and fail unless the pass message shows up in the output
simulate:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
